// File: include/lane_queue_defines.svh
`ifndef LANE_QUEUE_DEFINES_SVH
`define LANE_QUEUE_DEFINES_SVH

// Queue geometry
`define WORD_WIDTH 18
`define NUM_LANES  4
`define LANE_BITS  2
`define FIFO_DEPTH 3

`endif

// File: verilog/lane_queue_pkg.sv
`include "lane_queue_defines.svh"

package lane_queue_pkg;

    // One work item
    typedef logic [`WORD_WIDTH-1:0] word_t;

    typedef logic [`LANE_BITS-1:0] lane_idx_t;

    // Fill count 0..3
    typedef logic [1:0] fifo_pos_t;

endpackage

// File: verilog/lane_if.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

interface lane_if
    import lane_queue_pkg::*;
();

    word_t datain;
    logic  writeen;
    logic  shiften;
    word_t dataout;
    logic  empty;
    logic  full;

    modport distributor (
        output datain,
        output writeen,
        input  full
    );

    modport collector (
        output shiften,
        input  dataout,
        input  empty
    );

    modport fifo (
        input  datain,
        input  writeen,
        input  shiften,
        output dataout,
        output empty,
        output full
    );

endinterface

// File: verilog/lane_fifo3.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

module lane_fifo3
    import lane_queue_pkg::*;
(
    input  logic   clk,
    input  logic   globalreset,
    lane_if.fifo   q
);

    word_t     data0;
    word_t     data1;
    word_t     data2;
    fifo_pos_t pos;

    // Head entry is always visible
    assign q.dataout = data0;
    assign q.empty   = (pos == '0);
    assign q.full    = (pos == fifo_pos_t'(`FIFO_DEPTH));

    // Count only moves on a lone write or a lone shift
    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            pos <= '0;
        end
        else if (q.writeen && !q.shiften)
        begin
            pos <= pos + 1'b1;
        end
        else if (q.shiften && !q.writeen)
        begin
            pos <= pos - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (q.writeen && q.shiften)
        begin
            // Shift down and append behind what remains
            case (pos)
                2'd1:
                begin
                    data0 <= q.datain;
                end
                2'd2:
                begin
                    data0 <= data1;
                    data1 <= q.datain;
                end
                2'd3:
                begin
                    data0 <= data1;
                    data1 <= data2;
                    data2 <= q.datain;
                end
                default:
                begin
                    data0 <= data0;
                end
            endcase
        end
        else if (q.shiften)
        begin
            data0 <= data1;
            data1 <= data2;
        end
        else if (q.writeen)
        begin
            case (pos)
                2'd0:
                begin
                    data0 <= q.datain;
                end
                2'd1:
                begin
                    data1 <= q.datain;
                end
                2'd2:
                begin
                    data2 <= q.datain;
                end
                default:
                begin
                    data2 <= data2;
                end
            endcase
        end
    end

    // Neighbours must never underflow or overflow the lane
    a_no_shift_empty: assert property (
        @(posedge clk) disable iff (globalreset)
        q.shiften |-> !q.empty
    ) else $error("lane_fifo3: shift while empty");

    a_no_write_full: assert property (
        @(posedge clk) disable iff (globalreset)
        (q.writeen && q.full) |-> q.shiften
    ) else $error("lane_fifo3: write while full without shift");

endmodule

// File: verilog/lane_distributor.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

module lane_distributor
    import lane_queue_pkg::*;
(
    input  logic          clk,
    input  logic          globalreset,
    input  logic          in_valid,
    input  lane_idx_t     in_lane,
    input  word_t         in_data,
    output logic          drop,
    lane_if.distributor   lanes [`NUM_LANES-1:0]
);

    logic      in_valid_q;
    lane_idx_t in_lane_q;
    word_t     in_data_q;

    logic [`NUM_LANES-1:0] lane_full;
    logic [`NUM_LANES-1:0] write_vec;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            in_valid_q <= 1'b0;
        end
        else
        begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        in_lane_q <= in_lane;
        in_data_q <= in_data;
    end

    for (genvar i = 0; i < `NUM_LANES; i++)
    begin : g_lane
        assign lane_full[i] = lanes[i].full;
        // Only the addressed lane, and only if it has room
        assign write_vec[i] = in_valid_q && (in_lane_q == lane_idx_t'(i)) && !lane_full[i];
        assign lanes[i].writeen = write_vec[i];
        assign lanes[i].datain  = in_data_q;
    end

    // Full lane at the start of the cycle loses the word
    assign drop = in_valid_q && lane_full[in_lane_q];

    a_write_onehot: assert property (
        @(posedge clk) disable iff (globalreset)
        $onehot0(write_vec)
    ) else $error("lane_distributor: more than one lane written");

endmodule

// File: verilog/lane_collector.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

module lane_collector
    import lane_queue_pkg::*;
(
    input  logic          clk,
    input  logic          globalreset,
    input  logic          drain_en,
    lane_if.collector     lanes [`NUM_LANES-1:0],
    output logic          out_valid,
    output lane_idx_t     out_lane,
    output word_t         out_data
);

    lane_idx_t ptr;
    lane_idx_t sel;
    logic      found;
    logic      take;

    logic [`NUM_LANES-1:0] lane_empty;
    logic [`NUM_LANES-1:0] shift_vec;
    word_t                 head [`NUM_LANES];

    for (genvar i = 0; i < `NUM_LANES; i++)
    begin : g_lane
        assign lane_empty[i]    = lanes[i].empty;
        assign head[i]          = lanes[i].dataout;
        assign shift_vec[i]     = take && (sel == lane_idx_t'(i));
        assign lanes[i].shiften = shift_vec[i];
    end

    // First non-empty lane at or after the pointer
    always_comb
    begin
        found = 1'b0;
        sel   = ptr;
        for (int k = 0; k < `NUM_LANES; k++)
        begin
            if (!found && !lane_empty[lane_idx_t'(ptr + k)])
            begin
                found = 1'b1;
                sel   = lane_idx_t'(ptr + k);
            end
        end
    end

    assign take = drain_en && found;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            ptr       <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= take;
            if (take)
            begin
                ptr <= sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            out_lane <= sel;
            out_data <= head[sel];
        end
    end

    a_shift_onehot: assert property (
        @(posedge clk) disable iff (globalreset)
        $onehot0(shift_vec)
    ) else $error("lane_collector: more than one lane shifted");

endmodule

// File: verilog/lane_queue_top.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

module lane_queue_top
    import lane_queue_pkg::*;
(
    input  logic                   clk,
    input  logic                   globalreset,
    input  logic                   in_valid,
    input  logic [`LANE_BITS-1:0]  in_lane,
    input  logic [`WORD_WIDTH-1:0] in_data,
    input  logic                   drain_en,
    output logic                   drop,
    output logic                   out_valid,
    output logic [`LANE_BITS-1:0]  out_lane,
    output logic [`WORD_WIDTH-1:0] out_data
);

    lane_if lane_bus [`NUM_LANES-1:0] ();

    lane_distributor i_distributor (
        .clk         (clk),
        .globalreset (globalreset),
        .in_valid    (in_valid),
        .in_lane     (in_lane),
        .in_data     (in_data),
        .drop        (drop),
        .lanes       (lane_bus)
    );

    for (genvar i = 0; i < `NUM_LANES; i++)
    begin : g_fifo
        lane_fifo3 i_fifo (
            .clk         (clk),
            .globalreset (globalreset),
            .q           (lane_bus[i])
        );
    end

    lane_collector i_collector (
        .clk         (clk),
        .globalreset (globalreset),
        .drain_en    (drain_en),
        .lanes       (lane_bus),
        .out_valid   (out_valid),
        .out_lane    (out_lane),
        .out_data    (out_data)
    );

endmodule

// File: testbench/tb_lane_queue.sv
`timescale 1ns/1ns

`include "lane_queue_defines.svh"

module tb_lane_queue
    import lane_queue_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RANDOM_CYCLES = 500;
    // Reset, latency, ordering, overflow, fairness, random, final drains
    localparam int TEST_CYCLES   = 10 + 40 + 40 + 40 + 50 + RANDOM_CYCLES + 60;
    localparam int MARGIN_CYCLES = 200;
    // Longest a full subsystem needs to empty, with slack
    localparam int DRAIN_LIMIT   = 40;

    logic        clk;
    logic        globalreset;
    logic        in_valid;
    lane_idx_t   in_lane;
    word_t       in_data;
    logic        drain_en;
    logic        drop;
    logic        out_valid;
    lane_idx_t   out_lane;
    word_t       out_data;

    // Reference model
    word_t       model_q [`NUM_LANES][$];
    logic        stage_valid;
    lane_idx_t   stage_lane;
    word_t       stage_data;
    logic        exp_drop;
    logic        exp_hit;
    word_t       exp_data;
    int          pushed;
    int          popped;

    logic        lat_phase;
    logic        fair_phase;
    logic        prev_valid;
    lane_idx_t   last_lane;
    string       test_name;
    logic [15:0] lfsr;
    int          value_errors = 0;
    int          other_errors = 0;

    lane_queue_top i_dut (
        .clk         (clk),
        .globalreset (globalreset),
        .in_valid    (in_valid),
        .in_lane     (in_lane),
        .in_data     (in_data),
        .drain_en    (drain_en),
        .drop        (drop),
        .out_valid   (out_valid),
        .out_lane    (out_lane),
        .out_data    (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired before the tests completed");
        $display("Some tests failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("Fail %s: expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic report_other(input string what);
        other_errors++;
        $display("Error in %s: %s", test_name, what);
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int queued_total();
        int n;
        n = stage_valid ? 1 : 0;
        for (int l = 0; l < `NUM_LANES; l++)
            n += model_q[l].size();
        return n;
    endfunction

    // Runs mid-cycle where outputs are settled; expected values feed the assertions
    always @(negedge clk)
    begin
        if (globalreset)
        begin
            foreach (model_q[l])
                model_q[l].delete();
            stage_valid = 1'b0;
            exp_drop    = 1'b0;
            exp_hit     = 1'b1;
            exp_data    = '0;
            pushed      = 0;
            popped      = 0;
        end
        else
        begin
            // Pop first so a shift seen this cycle frees its slot
            exp_hit  = 1'b1;
            exp_data = '0;
            if (out_valid)
            begin
                if (model_q[out_lane].size() == 0)
                    exp_hit = 1'b0;
                else
                begin
                    exp_data = model_q[out_lane].pop_front();
                    popped++;
                end
            end
            exp_drop = 1'b0;
            if (stage_valid)
            begin
                if (model_q[stage_lane].size() >= `FIFO_DEPTH)
                    exp_drop = 1'b1;
                else
                begin
                    model_q[stage_lane].push_back(stage_data);
                    pushed++;
                end
            end
            stage_valid = in_valid;
            stage_lane  = in_lane;
            stage_data  = in_data;
        end
    end

    always @(posedge clk)
    begin
        prev_valid <= globalreset ? 1'b0 : out_valid;
        if (out_valid)
            last_lane <= out_lane;
    end

    a_reset_quiet: assert property (
        @(posedge clk) globalreset |=> (out_valid === 1'b0 && drop === 1'b0)
    ) else report_other("out_valid or drop high during or just after reset");

    a_drop: assert property (
        @(posedge clk) disable iff (globalreset) drop == exp_drop
    ) else report_mismatch({test_name, " drop"}, $sampled(exp_drop), $sampled(drop));

    a_known_word: assert property (
        @(posedge clk) disable iff (globalreset) out_valid |-> exp_hit
    ) else report_other("a word left a lane that should be empty");

    a_order: assert property (
        @(posedge clk) disable iff (globalreset)
        (out_valid && exp_hit) |-> out_data == exp_data
    ) else report_mismatch({test_name, " data"}, $sampled(exp_data), $sampled(out_data));

    a_latency: assert property (
        @(posedge clk) disable iff (globalreset)
        (lat_phase && in_valid) |-> ##3 (out_valid && out_lane == $past(in_lane, 3)
                                         && out_data == $past(in_data, 3))
    ) else report_other("strobed word did not leave on its lane three cycles later");

    a_fair: assert property (
        @(posedge clk) disable iff (globalreset)
        (fair_phase && out_valid && prev_valid) |-> out_lane == lane_idx_t'(last_lane + 1'b1)
    ) else report_mismatch("fairness", lane_idx_t'($sampled(last_lane) + 1'b1),
                           $sampled(out_lane));

    task automatic drive_word(input lane_idx_t lane, input word_t data);
        @(posedge clk);
        in_valid <= 1'b1;
        in_lane  <= lane;
        in_data  <= data;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        idle(3);
        while (queued_total() != 0 && n < DRAIN_LIMIT)
        begin
            idle(1);
            n++;
        end
        idle(2);
    endtask

    initial
    begin
        logic [31:0] r;
        globalreset <= 1'b1;
        in_valid    <= 1'b0;
        in_lane     <= '0;
        in_data     <= '0;
        drain_en    <= 1'b1;
        lat_phase   <= 1'b0;
        fair_phase  <= 1'b0;
        lfsr        = 16'd42;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        globalreset <= 1'b0;
        idle(3);

        test_name = "latency";
        lat_phase <= 1'b1;
        for (int l = 0; l < `NUM_LANES; l++)
        begin
            drive_word(lane_idx_t'(l), word_t'(18'h10a0 + l));
            idle(6);
        end
        lat_phase <= 1'b0;

        test_name = "ordering";
        drain_en <= 1'b0;
        drive_word(2'd1, 18'h0a001);
        drive_word(2'd1, 18'h0a002);
        drive_word(2'd3, 18'h0b001);
        drive_word(2'd1, 18'h0a003);
        drive_word(2'd3, 18'h0b002);
        idle(2);
        drain_en <= 1'b1;
        wait_drained();

        // Fourth word finds the lane full
        test_name = "overflow";
        drain_en <= 1'b0;
        for (int k = 0; k < 4; k++)
            drive_word(2'd2, word_t'(18'h2c000 + k));
        idle(3);
        drain_en <= 1'b1;
        wait_drained();

        test_name = "fairness";
        drain_en <= 1'b0;
        for (int k = 0; k < `FIFO_DEPTH; k++)
            for (int l = 0; l < `NUM_LANES; l++)
                drive_word(lane_idx_t'(l), word_t'(18'h30000 + 16 * k + l));
        idle(2);
        fair_phase <= 1'b1;
        drain_en   <= 1'b1;
        wait_drained();
        fair_phase <= 1'b0;

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            @(posedge clk);
            random_bits(2, r);
            in_valid <= (r[1:0] != 2'b00);
            random_bits(`LANE_BITS, r);
            in_lane <= lane_idx_t'(r);
            random_bits(`WORD_WIDTH, r);
            in_data <= word_t'(r);
            random_bits(2, r);
            drain_en <= (r[1:0] != 2'b00);
        end
        idle(1);
        drain_en <= 1'b1;
        wait_drained();
        a_all_left: assert (pushed == popped)
            else report_mismatch("random words out", pushed, popped);

        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
verilog/lane_queue_pkg.sv
verilog/lane_if.sv
verilog/lane_fifo3.sv
verilog/lane_distributor.sv
verilog/lane_collector.sv
verilog/lane_queue_top.sv
testbench/tb_lane_queue.sv
